// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_rocache -f files.f -Mdir obj_dir
	./obj_dir/Vtb_rocache > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
logic/rocache_pkg.sv
logic/rocache_req_fifo.sv
logic/rocache_lookup.sv
logic/rocache_ctrl.sv
logic/rocache_top.sv
testbench/rocache_chk.sv
testbench/rocache_checker.sv
testbench/tb_rocache.sv

// File: logic/rocache_ctrl.sv
////////////////////////////////////////////////////////////
// Sequencer of the read-only cache
// Cacheability decode, hit, miss and bypass handling,
// line refill and in-order response forming
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rocache_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic [rocache_pkg::ADDR_W-1:0] cache_start_i,
  input  logic [rocache_pkg::ADDR_W-1:0] cache_end_i,
  input  rocache_pkg::req_entry_t        head_data_i,
  input  logic                           head_empty_i,
  output logic                           pop_o,
  output logic                           lookup_valid_o,
  output logic [rocache_pkg::ADDR_W-1:0] lookup_addr_o,
  input  logic                           lookup_hit_i,
  input  logic [rocache_pkg::LINE_W-1:0] lookup_line_i,
  output logic                           fill_valid_o,
  output logic [rocache_pkg::ADDR_W-1:0] fill_addr_o,
  output logic [rocache_pkg::LINE_W-1:0] fill_line_o,
  output logic                           mem_req_valid_o,
  output logic [rocache_pkg::ADDR_W-1:0] mem_req_addr_o,
  input  logic                           mem_rsp_valid_i,
  input  logic [rocache_pkg::LINE_W-1:0] mem_rsp_data_i,
  input  logic                           mem_rsp_err_i,
  output logic                           rsp_valid_o,
  output logic [rocache_pkg::DATA_W-1:0] rsp_data_o,
  output logic [rocache_pkg::ID_W-1:0]   rsp_id_o,
  output logic                           rsp_err_o
);

  import rocache_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOK,
    ST_MEM_WAIT,
    ST_RESPOND
  } state_e;

  state_e            state_q;
  state_e            state_d;
  req_entry_t        req_q;
  logic              cacheable_q;
  logic              mem_req_q;
  logic              flush_seen_q;
  logic [DATA_W-1:0] rsp_data_q;
  logic              rsp_err_q;
  logic              head_cacheable;
  logic              look_hit;
  logic              mem_done;

  // Pick one word out of a line by the word offset of the address
  function automatic logic [DATA_W-1:0] pick_word(logic [LINE_W-1:0] line,
                                                  logic [ADDR_W-1:0] addr);
    logic [WORD_SEL_W-1:0] sel;
    sel = addr[BYTE_OFS_W +: WORD_SEL_W];
    return line[sel * DATA_W +: DATA_W];
  endfunction

  // Single range rule with inclusive start and exclusive end
  assign head_cacheable = (head_data_i.addr >= cache_start_i) && (head_data_i.addr < cache_end_i);

  // A bypass never counts as a hit, even if a stale tag matches
  assign look_hit = (state_q == ST_LOOK) && lookup_hit_i && cacheable_q;
  assign mem_done = (state_q == ST_MEM_WAIT) && mem_rsp_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (!head_empty_i) begin
          state_d = ST_LOOK;
        end
      end
      ST_LOOK:     state_d = look_hit ? ST_RESPOND : ST_MEM_WAIT;
      ST_MEM_WAIT: begin
        if (mem_rsp_valid_i) begin
          state_d = ST_RESPOND;
        end
      end
      ST_RESPOND:  state_d = ST_IDLE;
      default:     state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      cacheable_q  <= 1'b0;
      mem_req_q    <= 1'b0;
      flush_seen_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // One-cycle memory request right after a miss or bypass
      mem_req_q <= (state_q == ST_LOOK) && !look_hit;
      if (pop_o) begin
        cacheable_q <= head_cacheable;
      end
      // Line fetched across a flush must not be filled
      if (state_q == ST_LOOK) begin
        flush_seen_q <= 1'b0;
      end else if (flush_i && (state_q == ST_MEM_WAIT)) begin
        flush_seen_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      req_q <= head_data_i;
    end
    if (look_hit) begin
      rsp_data_q <= pick_word(lookup_line_i, req_q.addr);
      rsp_err_q  <= 1'b0;
    end else if (mem_done) begin
      rsp_data_q <= pick_word(mem_rsp_data_i, req_q.addr);
      rsp_err_q  <= mem_rsp_err_i;
    end
  end

  // Head is taken and looked up in the same cycle
  assign pop_o          = (state_q == ST_IDLE) && !head_empty_i;
  assign lookup_valid_o = pop_o;
  assign lookup_addr_o  = head_data_i.addr;

  assign mem_req_valid_o = mem_req_q;
  assign mem_req_addr_o  = {req_q.addr[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};

  // Fill lands at the edge where the response goes out
  assign fill_valid_o = mem_done && cacheable_q && !mem_rsp_err_i && !flush_seen_q;
  assign fill_addr_o  = req_q.addr;
  assign fill_line_o  = mem_rsp_data_i;

  assign rsp_valid_o = (state_q == ST_RESPOND);
  assign rsp_data_o  = rsp_data_q;
  assign rsp_id_o    = req_q.id;
  assign rsp_err_o   = rsp_err_q;

endmodule

// File: logic/rocache_lookup.sv
////////////////////////////////////////////////////////////
// Line storage of the read-only cache
// Tag, valid and data arrays, registered lookup,
// line write port and flush of all valid bits
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rocache_lookup (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           lookup_valid_i,
  input  logic [rocache_pkg::ADDR_W-1:0] lookup_addr_i,
  output logic                           lookup_hit_o,
  output logic [rocache_pkg::LINE_W-1:0] lookup_line_o,
  input  logic                           fill_valid_i,
  input  logic [rocache_pkg::ADDR_W-1:0] fill_addr_i,
  input  logic [rocache_pkg::LINE_W-1:0] fill_line_i
);

  import rocache_pkg::*;

  logic [TAG_W-1:0]      tag_q  [LINE_COUNT];
  logic [LINE_W-1:0]     line_q [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid_q;

  logic [IDX_W-1:0] lookup_idx;
  logic [TAG_W-1:0] lookup_tag;
  logic [IDX_W-1:0] fill_idx;
  logic [TAG_W-1:0] fill_tag;
  logic             fill_en;

  // Index sits just above the line offset in a direct-mapped cache
  assign lookup_idx = lookup_addr_i[OFS_W +: IDX_W];
  assign lookup_tag = lookup_addr_i[ADDR_W-1 -: TAG_W];
  assign fill_idx   = fill_addr_i[OFS_W +: IDX_W];
  assign fill_tag   = fill_addr_i[ADDR_W-1 -: TAG_W];

  // Flush wins over a fill in the same cycle
  assign fill_en = fill_valid_i && !flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_en) begin
      tag_q[fill_idx]  <= fill_tag;
      line_q[fill_idx] <= fill_line_i;
    end
  end

  // Registered tag compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lookup_hit_o <= 1'b0;
    end else if (lookup_valid_i) begin
      lookup_hit_o <= valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    end
  end

  // Registered line read that lines up with the hit flag
  always_ff @(posedge clk_i) begin
    if (lookup_valid_i) begin
      lookup_line_o <= line_q[lookup_idx];
    end
  end

endmodule

// File: logic/rocache_pkg.sv
////////////////////////////////////////////////////////////
// Read-only constant cache shared definitions
// Address, data and line geometry, request queue depth
// and the pending-request entry type
////////////////////////////////////////////////////////////
package rocache_pkg;

  // Address and data words
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // Line geometry
  localparam int unsigned WORDS_PER_LINE = 4;
  localparam int unsigned LINE_W         = DATA_W * WORDS_PER_LINE;
  localparam int unsigned LINE_COUNT     = 8;
  localparam int unsigned IDX_W          = $clog2(LINE_COUNT);
  localparam int unsigned OFS_W          = $clog2(LINE_W / 8);
  localparam int unsigned TAG_W          = ADDR_W - IDX_W - OFS_W;

  // Split of the line offset into word select and byte bits
  localparam int unsigned BYTE_OFS_W = $clog2(DATA_W / 8);
  localparam int unsigned WORD_SEL_W = $clog2(WORDS_PER_LINE);

  // Requester side
  localparam int unsigned ID_W        = 4;
  localparam int unsigned QUEUE_DEPTH = 4;

  // One accepted read waiting for the sequencer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } req_entry_t;

endpackage

// File: logic/rocache_req_fifo.sv
////////////////////////////////////////////////////////////
// Request queue for the read-only cache
// Circular buffer with occupancy count, head shown without pop
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rocache_req_fifo #(
  parameter type         entry_t = logic,
  parameter int unsigned DEPTH   = 4
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   in_valid_i,
  input  entry_t in_data_i,
  input  logic   pop_i,
  output entry_t out_data_o,
  output logic   empty_o,
  output logic   full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  entry_t           mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Wrap at DEPTH so non power of two depths also work
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push = in_valid_i && !full_o;
  assign pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  assign out_data_o = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign full_o     = (count_q == CNT_W'(DEPTH));

endmodule

// File: logic/rocache_top.sv
////////////////////////////////////////////////////////////
// Read-only constant cache top level
// Request queue, line storage and sequencer
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rocache_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_valid_i,
  input  logic [rocache_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [rocache_pkg::ID_W-1:0]   req_id_i,
  output logic                           rsp_valid_o,
  output logic [rocache_pkg::DATA_W-1:0] rsp_data_o,
  output logic [rocache_pkg::ID_W-1:0]   rsp_id_o,
  output logic                           rsp_err_o,
  input  logic [rocache_pkg::ADDR_W-1:0] cache_start_i,
  input  logic [rocache_pkg::ADDR_W-1:0] cache_end_i,
  input  logic                           flush_i,
  output logic                           mem_req_valid_o,
  output logic [rocache_pkg::ADDR_W-1:0] mem_req_addr_o,
  input  logic                           mem_rsp_valid_i,
  input  logic [rocache_pkg::LINE_W-1:0] mem_rsp_data_i,
  input  logic                           mem_rsp_err_i
);

  import rocache_pkg::*;

  req_entry_t        queue_head;
  logic              queue_empty;
  logic              queue_full;
  logic              pop;
  logic              lookup_valid;
  logic [ADDR_W-1:0] lookup_addr;
  logic              lookup_hit;
  logic [LINE_W-1:0] lookup_line;
  logic              fill_valid;
  logic [ADDR_W-1:0] fill_addr;
  logic [LINE_W-1:0] fill_line;

  rocache_req_fifo #(
    .entry_t ( req_entry_t ),
    .DEPTH   ( QUEUE_DEPTH )
  ) u_req_fifo (
    .clk_i      ( clk_i                    ),
    .rst_ni     ( rst_ni                   ),
    .in_valid_i ( req_valid_i              ),
    .in_data_i  ( {req_addr_i, req_id_i}   ),
    .pop_i      ( pop                      ),
    .out_data_o ( queue_head               ),
    .empty_o    ( queue_empty              ),
    .full_o     ( queue_full               )
  );

  rocache_lookup u_lookup (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .flush_i        ( flush_i      ),
    .lookup_valid_i ( lookup_valid ),
    .lookup_addr_i  ( lookup_addr  ),
    .lookup_hit_o   ( lookup_hit   ),
    .lookup_line_o  ( lookup_line  ),
    .fill_valid_i   ( fill_valid   ),
    .fill_addr_i    ( fill_addr    ),
    .fill_line_i    ( fill_line    )
  );

  rocache_ctrl u_ctrl (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .cache_start_i   ( cache_start_i   ),
    .cache_end_i     ( cache_end_i     ),
    .head_data_i     ( queue_head      ),
    .head_empty_i    ( queue_empty     ),
    .pop_o           ( pop             ),
    .lookup_valid_o  ( lookup_valid    ),
    .lookup_addr_o   ( lookup_addr     ),
    .lookup_hit_i    ( lookup_hit      ),
    .lookup_line_i   ( lookup_line     ),
    .fill_valid_o    ( fill_valid      ),
    .fill_addr_o     ( fill_addr       ),
    .fill_line_o     ( fill_line       ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .mem_rsp_data_i  ( mem_rsp_data_i  ),
    .mem_rsp_err_i   ( mem_rsp_err_i   ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_data_o      ( rsp_data_o      ),
    .rsp_id_o        ( rsp_id_o        ),
    .rsp_err_o       ( rsp_err_o       )
  );

endmodule

// File: testbench/rocache_checker.sv
////////////////////////////////////////////////////////////
// Response checker for the read-only cache
// In-order compare of ID, data and error flag,
// extra and missing response detection
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rocache_checker (
  input  logic                           clk_i,
  input  logic                           exp_valid_i,
  input  logic [rocache_pkg::ID_W-1:0]   exp_id_i,
  input  logic [rocache_pkg::DATA_W-1:0] exp_data_i,
  input  logic                           exp_err_i,
  input  logic                           rsp_valid_i,
  input  logic [rocache_pkg::ID_W-1:0]   rsp_id_i,
  input  logic [rocache_pkg::DATA_W-1:0] rsp_data_i,
  input  logic                           rsp_err_i,
  input  logic                           done_i,
  output int                             checked_o,
  output int                             errors_o
);

  import rocache_pkg::*;

  logic [ID_W-1:0]   id_q   [$];
  logic [DATA_W-1:0] data_q [$];
  logic              err_q  [$];
  logic              done_seen = 1'b0;
  int                checked   = 0;
  int                errors    = 0;

  assign checked_o = checked;
  assign errors_o  = errors;

  always @(posedge clk_i) begin : compare
    logic [ID_W-1:0]   want_id;
    logic [DATA_W-1:0] want_data;
    logic              want_err;
    // A new expectation is queued before any compare in the same cycle
    if (exp_valid_i) begin
      id_q.push_back(exp_id_i);
      data_q.push_back(exp_data_i);
      err_q.push_back(exp_err_i);
    end
    if (rsp_valid_i) begin
      if (id_q.size() == 0) begin
        errors++;
        $display("Response with ID %h arrived while no read was outstanding", rsp_id_i);
      end else begin
        want_id   = id_q.pop_front();
        want_data = data_q.pop_front();
        want_err  = err_q.pop_front();
        checked++;
        if (rsp_id_i !== want_id) begin
          errors++;
          $display("Error: rsp_id_o is %h, expected %h", rsp_id_i, want_id);
        end
        if (rsp_data_i !== want_data) begin
          errors++;
          $display("Error: rsp_data_o is %h, expected %h (ID %h)", rsp_data_i, want_data,
                   want_id);
        end
        if (rsp_err_i !== want_err) begin
          errors++;
          $display("Error: rsp_err_o is %h, expected %h (ID %h)", rsp_err_i, want_err, want_id);
        end
      end
    end
    if (done_i && !done_seen) begin
      done_seen = 1'b1;
      if (id_q.size() != 0) begin
        errors += id_q.size();
        $display("%0d expected responses never arrived", id_q.size());
      end
    end
  end

endmodule

// File: testbench/rocache_chk.sv
////////////////////////////////////////////////////////////
// Protocol assertions for the read-only cache
// Bound into the top level
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rocache_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic queue_full_i,
  input logic mem_req_valid_i,
  input logic mem_rsp_valid_i,
  input logic rsp_valid_i
);

  // Set while a backing-memory read waits for its answer
  logic mem_busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_busy_q <= 1'b0;
    end else if (mem_req_valid_i) begin
      mem_busy_q <= 1'b1;
    end else if (mem_rsp_valid_i) begin
      mem_busy_q <= 1'b0;
    end
  end

  no_req_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_valid_i && queue_full_i))
    else $error("A request arrived while the request queue was full");

  single_mem_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_i |-> !mem_busy_q)
    else $error("A memory read was issued while another one was outstanding");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!rsp_valid_i && !mem_req_valid_i))
    else $error("A response or memory read strobe was high during reset");

endmodule

bind rocache_top rocache_chk u_chk (
  .clk_i           ( clk_i           ),
  .rst_ni          ( rst_ni          ),
  .req_valid_i     ( req_valid_i     ),
  .queue_full_i    ( queue_full      ),
  .mem_req_valid_i ( mem_req_valid_o ),
  .mem_rsp_valid_i ( mem_rsp_valid_i ),
  .rsp_valid_i     ( rsp_valid_o     )
);

// File: testbench/rocache_testdata.txt
# R addr id expected_word expected_err | M addr word | F | I idle_cycles
# All numbers are hex, cacheable window is 1000 up to ff00
I 4
R 1100 1 eeff1100 0
M 1100 12345678
R 1100 2 eeff1100 0
R 1104 3 eefb1104 0
R 1108 4 eef71108 0
R 110c 5 eef3110c 0
R 0200 6 fdff0200 0
M 0200 cafef00d
R 0200 7 cafef00d 0
R 0200 8 cafef00d 0
F
R 1100 9 12345678 0
R f000 a 0ffff000 1
R f000 b 0ffff000 1
I 6
R 1104 c eefb1104 0
R 2010 d dfef2010 0
R 1108 e eef71108 0
R 2014 f dfeb2014 0
R 0300 0 fcff0300 0
R 110c 1 eef3110c 0

// File: testbench/tb_rocache.sv
////////////////////////////////////////////////////////////
// Testbench top for the read-only cache
// Clock, reset, test data driver, backing-memory model
// and the response checker instance
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_rocache;

  import rocache_pkg::*;

  localparam int    WAIT_LIMIT = 300;
  localparam string DATA_FILE  = "testbench/rocache_testdata.txt";

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              req_valid_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [ID_W-1:0]   req_id_i;
  logic              rsp_valid_o;
  logic [DATA_W-1:0] rsp_data_o;
  logic [ID_W-1:0]   rsp_id_o;
  logic              rsp_err_o;
  logic [ADDR_W-1:0] cache_start_i;
  logic [ADDR_W-1:0] cache_end_i;
  logic              flush_i;
  logic              mem_req_valid_o;
  logic [ADDR_W-1:0] mem_req_addr_o;
  logic              mem_rsp_valid_i;
  logic [LINE_W-1:0] mem_rsp_data_i;
  logic              mem_rsp_err_i;

  // Expected response handed to the checker with each read
  logic              exp_valid;
  logic [ID_W-1:0]   exp_id;
  logic [DATA_W-1:0] exp_data;
  logic              exp_err;
  logic              check_done;
  int                checked_count;
  int                checker_errors;

  // Backing memory with one entry per 32-bit word
  logic [DATA_W-1:0] mem_words [1 << (ADDR_W - 2)];
  logic [ADDR_W-1:0] mem_line_addr;
  int                mem_delay;
  integer            seed = 32'h28ae990b;

  int sent_count = 0;
  int rsp_count  = 0;
  int tb_errors  = 0;

  rocache_top u_dut (.*);

  rocache_checker u_checker (
    .clk_i       ( clk_i          ),
    .exp_valid_i ( exp_valid      ),
    .exp_id_i    ( exp_id         ),
    .exp_data_i  ( exp_data       ),
    .exp_err_i   ( exp_err        ),
    .rsp_valid_i ( rsp_valid_o    ),
    .rsp_id_i    ( rsp_id_o       ),
    .rsp_data_i  ( rsp_data_o     ),
    .rsp_err_i   ( rsp_err_o      ),
    .done_i      ( check_done     ),
    .checked_o   ( checked_count  ),
    .errors_o    ( checker_errors )
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_count <= 0;
    end else if (rsp_valid_o) begin
      rsp_count <= rsp_count + 1;
    end
  end

  // Memory model answers each line read after 2 to 6 cycles
  initial begin
    mem_rsp_valid_i = 1'b0;
    mem_rsp_data_i  = '0;
    mem_rsp_err_i   = 1'b0;
    forever begin
      @(posedge clk_i);
      if (mem_req_valid_o) begin
        mem_line_addr = mem_req_addr_o;
        mem_delay     = 2 + int'($unsigned($random(seed)) % 5);
        repeat (mem_delay - 1) @(posedge clk_i);
        #2;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          mem_rsp_data_i[w*DATA_W +: DATA_W] =
            mem_words[{mem_line_addr[ADDR_W-1:OFS_W], WORD_SEL_W'(w)}];
        end
        // Top nibble F is a region that answers with a bus error
        mem_rsp_err_i   = (mem_line_addr[ADDR_W-1 -: 4] == 4'hf);
        mem_rsp_valid_i = 1'b1;
        @(posedge clk_i);
        #2;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_err_i   = 1'b0;
      end
    end
  end

  task automatic wait_outstanding(input int limit, input string what);
    int cycles;
    cycles = 0;
    while ((sent_count - rsp_count) > limit && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    if ((sent_count - rsp_count) > limit) begin
      tb_errors++;
      $display("Timeout after %0d cycles while waiting for %s", WAIT_LIMIT, what);
    end
  endtask

  task automatic send_read(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
                           input logic [DATA_W-1:0] data, input logic err);
    wait_outstanding(int'(QUEUE_DEPTH) - 1, "room in the request queue");
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_id_i    = id;
    exp_valid   = 1'b1;
    exp_id      = id;
    exp_data    = data;
    exp_err     = err;
    sent_count++;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    exp_valid   = 1'b0;
  endtask

  task automatic send_flush();
    @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    byte         op;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    req_id_i    = '0;
    flush_i     = 1'b0;
    exp_valid   = 1'b0;
    exp_id      = '0;
    exp_data    = '0;
    exp_err     = 1'b0;
    check_done  = 1'b0;
    // Addresses below the cacheable window bypass the cache
    cache_start_i = 16'h1000;
    cache_end_i   = 16'hff00;
    // Each word holds its byte address, inverted in the upper half
    for (int i = 0; i < (1 << (ADDR_W - 2)); i++) begin
      mem_words[i] = {~ADDR_W'(i * 4), ADDR_W'(i * 4)};
    end
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      tb_errors++;
      $display("Could not open the test data file %s", DATA_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        fields = $sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4);
        case (op)
          "R": begin
            if (fields == 5) begin
              send_read(f1[ADDR_W-1:0], f2[ID_W-1:0], f3, f4[0]);
            end else begin
              tb_errors++;
              $display("Malformed read line in the test data: %s", line);
            end
          end
          "M": begin
            // Memory changes only once the cache has nothing in flight
            wait_outstanding(0, "responses before a memory write");
            mem_words[f1[ADDR_W-1:2]] = f2;
          end
          "F": begin
            wait_outstanding(0, "responses before a flush");
            send_flush();
          end
          "I": repeat (f1) @(posedge clk_i);
          default: ;
        endcase
      end
      $fclose(fd);
    end

    wait_outstanding(0, "the last responses");
    @(posedge clk_i);
    #2;
    check_done = 1'b1;
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d reads sent, %0d checked, %0d checker errors, %0d testbench errors",
             sent_count, checked_count, checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
